/* src/cu_pkg.sv */
////////////////////
// widths and unit ids shared by the graph compute unit
// read data word with its vertex and edge record views
////////////////////

package cu_pkg;

	parameter int ADDR_BITS       = 16;
	parameter int COUNT_BITS      = 16;
	parameter int WEIGHT_SUM_BITS = 24;
	parameter int DEGREE_BITS     = 8;
	parameter int WEIGHT_BITS     = 8;

	// unit ids carried on commands and on read data
	parameter logic VERTEX_CONTROL_ID = 1'b0;
	parameter logic EDGE_CONTROL_ID   = 1'b1;

	// one memory word, decoded by whichever unit asked for it
	typedef union packed {
		struct packed {
			logic [15:0]            first_edge;
			logic [DEGREE_BITS-1:0] degree;
			logic [7:0]             pad;
		} vertex_view;
		struct packed {
			logic [15:0]            dest_vertex;
			logic [WEIGHT_BITS-1:0] weight;
			logic [7:0]             pad;
		} edge_view;
	} graph_word;

endpackage

/* src/cmd_fifo.sv */
////////////////////
// synchronous FIFO with full, almost-full and empty flags
// head word is visible on data_out before the pop
////////////////////

module cmd_fifo #(
	parameter int WIDTH = 16,
	parameter int DEPTH = 8
) (
	input  logic             clock,
	input  logic             rstn,
	input  logic             push,
	input  logic [WIDTH-1:0] data_in,
	input  logic             pop,
	output logic [WIDTH-1:0] data_out,
	output logic             full,
	output logic             alfull,
	output logic             empty
);

	localparam int PTR_BITS = $clog2(DEPTH);

	logic [WIDTH-1:0]    mem [DEPTH];
	logic [PTR_BITS-1:0] wr_ptr;
	logic [PTR_BITS-1:0] rd_ptr;
	logic [PTR_BITS:0]   count;

	always_ff @(posedge clock) begin
		if (push) begin
			mem[wr_ptr] <= data_in;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign data_out = mem[rd_ptr];
	assign full     = count == (PTR_BITS+1)'(DEPTH);
	// two slots of slack for a requester whose push is registered
	assign alfull   = count >= (PTR_BITS+1)'(DEPTH - 2);
	assign empty    = count == '0;

	assert property (@(posedge clock) disable iff (!rstn) push |-> !full)
		else $error("cmd_fifo: push while full");
	assert property (@(posedge clock) disable iff (!rstn) pop |-> !empty)
		else $error("cmd_fifo: pop while empty");

endmodule

/* src/cmd_arbiter.sv */
////////////////////
// round-robin arbiter over the command FIFO heads
// registered command out, unit id is the grant index
////////////////////

module cmd_arbiter #(
	parameter int NUM_REQUESTS = 2
) (
	input  logic                                          clock,
	input  logic                                          rstn,
	input  logic                                          enable_in,
	input  logic [NUM_REQUESTS-1:0]                       requests,
	input  logic [NUM_REQUESTS-1:0][cu_pkg::ADDR_BITS-1:0] cmd_in,
	output logic [NUM_REQUESTS-1:0]                       ready,
	output logic                                          cmd_out_valid,
	output logic [$clog2(NUM_REQUESTS)+cu_pkg::ADDR_BITS-1:0] cmd_out
);

	localparam int ID_BITS = $clog2(NUM_REQUESTS);

	logic [ID_BITS-1:0] last_grant;
	logic [ID_BITS-1:0] grant_idx;
	logic               grant_any;

	// search starts one past the last winner
	always_comb begin
		int unsigned idx;
		grant_idx = last_grant;
		grant_any = 1'b0;
		ready     = '0;
		for (int i = 1; i <= NUM_REQUESTS; i++) begin
			idx = (int'(last_grant) + i) % NUM_REQUESTS;
			if (enable_in && !grant_any && requests[idx]) begin
				grant_any  = 1'b1;
				grant_idx  = ID_BITS'(idx);
				ready[idx] = 1'b1;
			end
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			last_grant    <= '0;
			cmd_out_valid <= 1'b0;
			cmd_out       <= '0;
		end else begin
			cmd_out_valid <= grant_any;
			if (grant_any) begin
				last_grant <= grant_idx;
				cmd_out    <= {grant_idx, cmd_in[grant_idx]};
			end
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) $onehot0(ready))
		else $error("cmd_arbiter: more than one grant");

endmodule

/* src/vertex_job_control.sv */
////////////////////
// vertex record reads and the vertex job queue
// zero-degree vertices are counted as filtered
////////////////////

module vertex_job_control #(
	parameter int FIFO_DEPTH = 8
) (
	input  logic                           clock,
	input  logic                           rstn,
	input  logic                           enable_in,
	input  logic                           start,
	input  logic [cu_pkg::COUNT_BITS-1:0]  num_vertices,
	input  logic [cu_pkg::ADDR_BITS-1:0]   vertex_base,
	input  logic                           data_valid,
	input  cu_pkg::graph_word              data,
	input  logic                           cmd_alfull,
	output logic                           cmd_push,
	output logic [cu_pkg::ADDR_BITS-1:0]   cmd_addr,
	input  logic                           job_request,
	output logic                           job_valid,
	output logic [cu_pkg::COUNT_BITS-1:0]  job_edge_start,
	output logic [cu_pkg::DEGREE_BITS-1:0] job_degree,
	output logic [cu_pkg::COUNT_BITS-1:0]  filtered_count
);

	// reads in flight, kept low so every return fits the job queue
	localparam logic [1:0] MAX_OUTSTANDING = 2'd2;

	logic [cu_pkg::ADDR_BITS-1:0]  next_addr;
	logic [cu_pkg::COUNT_BITS-1:0] reads_left;
	logic [1:0]                    outstanding;
	logic                          issue;
	logic                          job_push;
	logic                          job_alfull;
	logic                          job_empty;
	logic [cu_pkg::COUNT_BITS+cu_pkg::DEGREE_BITS-1:0] job_out;

	assign issue = enable_in && reads_left != '0 && !cmd_alfull && !job_alfull
		&& outstanding < MAX_OUTSTANDING;
	assign job_push = data_valid && data.vertex_view.degree != '0;

	////////////////////
	// address walk
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			next_addr      <= '0;
			reads_left     <= '0;
			outstanding    <= '0;
			cmd_push       <= 1'b0;
			cmd_addr       <= '0;
			filtered_count <= '0;
		end else if (start) begin
			next_addr      <= vertex_base;
			reads_left     <= num_vertices;
			outstanding    <= '0;
			cmd_push       <= 1'b0;
			filtered_count <= '0;
		end else begin
			cmd_push <= issue;
			if (issue) begin
				cmd_addr   <= next_addr;
				next_addr  <= next_addr + 1'b1;
				reads_left <= reads_left - 1'b1;
			end
			outstanding <= outstanding + {1'b0, issue} - {1'b0, data_valid};
			if (data_valid && !job_push) begin
				filtered_count <= filtered_count + 1'b1;
			end
		end
	end

	////////////////////
	// job queue
	////////////////////

	cmd_fifo #(
		.WIDTH(cu_pkg::COUNT_BITS + cu_pkg::DEGREE_BITS),
		.DEPTH(FIFO_DEPTH)
	) u_job_fifo (
		.clock   (clock),
		.rstn    (rstn),
		.push    (job_push),
		.data_in ({data.vertex_view.first_edge, data.vertex_view.degree}),
		.pop     (job_request),
		.data_out(job_out),
		.full    (),
		.alfull  (job_alfull),
		.empty   (job_empty)
	);

	assign job_valid = !job_empty;
	assign {job_edge_start, job_degree} = job_out;

	// memory must not answer a vertex read that was never issued
	assert property (@(posedge clock) disable iff (!rstn) data_valid |-> outstanding != '0)
		else $error("vertex_job_control: unexpected vertex record");

endmodule

/* src/edge_job_control.sv */
////////////////////
// expands one vertex job at a time into edge reads
// counts edges and finished vertices, sums edge weights
////////////////////

module edge_job_control (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               enable_in,
	input  logic                               start,
	input  logic [cu_pkg::ADDR_BITS-1:0]       edge_base,
	input  logic                               job_valid,
	input  logic [cu_pkg::COUNT_BITS-1:0]      job_edge_start,
	input  logic [cu_pkg::DEGREE_BITS-1:0]     job_degree,
	output logic                               job_request,
	input  logic                               cmd_alfull,
	output logic                               cmd_push,
	output logic [cu_pkg::ADDR_BITS-1:0]       cmd_addr,
	input  logic                               data_valid,
	input  cu_pkg::graph_word                  data,
	output logic [cu_pkg::COUNT_BITS-1:0]      vertex_done_count,
	output logic [cu_pkg::COUNT_BITS-1:0]      edge_done_count,
	output logic [cu_pkg::WEIGHT_SUM_BITS-1:0] weight_sum
);

	localparam logic IDLE = 1'b0;
	localparam logic BUSY = 1'b1;
	localparam int   PAD_BITS = cu_pkg::WEIGHT_SUM_BITS - cu_pkg::WEIGHT_BITS;

	logic                           state;
	logic [cu_pkg::COUNT_BITS-1:0]  edge_index;
	logic [cu_pkg::DEGREE_BITS-1:0] issue_left;
	logic [cu_pkg::DEGREE_BITS-1:0] remaining;
	logic                           issue;
	logic                           last_return;

	// head fields are taken in the same cycle as the pop
	assign job_request = state == IDLE && enable_in && job_valid;
	assign issue       = state == BUSY && enable_in && issue_left != '0 && !cmd_alfull;
	assign last_return = state == BUSY && data_valid && remaining == 1;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state             <= IDLE;
			edge_index        <= '0;
			issue_left        <= '0;
			remaining         <= '0;
			cmd_push          <= 1'b0;
			cmd_addr          <= '0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
			weight_sum        <= '0;
		end else if (start) begin
			state             <= IDLE;
			cmd_push          <= 1'b0;
			vertex_done_count <= '0;
			edge_done_count   <= '0;
			weight_sum        <= '0;
		end else begin
			cmd_push <= issue;
			if (issue) begin
				cmd_addr   <= edge_base + edge_index;
				edge_index <= edge_index + 1'b1;
				issue_left <= issue_left - 1'b1;
			end
			if (data_valid) begin
				edge_done_count <= edge_done_count + 1'b1;
				weight_sum      <= weight_sum + {{PAD_BITS{1'b0}}, data.edge_view.weight};
				remaining       <= remaining - 1'b1;
			end
			case (state)
				IDLE: begin
					if (job_request) begin
						state      <= BUSY;
						edge_index <= job_edge_start;
						issue_left <= job_degree;
						remaining  <= job_degree;
					end
				end
				BUSY: begin
					// last edge of this vertex is back
					if (last_return) begin
						state             <= IDLE;
						vertex_done_count <= vertex_done_count + 1'b1;
					end
				end
			endcase
		end
	end

	assert property (@(posedge clock) disable iff (!rstn) data_valid |-> state == BUSY)
		else $error("edge_job_control: edge data with no active job");

endmodule

/* src/cu_control.sv */
////////////////////
// top of the graph compute unit
// input latches, read data routing by unit id,
// command FIFOs, arbiter and completion status
////////////////////

module cu_control #(
	parameter int CMD_FIFO_DEPTH = 8,
	parameter int NUM_REQUESTS   = 2
) (
	input  logic                               clock,
	input  logic                               rstn,
	input  logic                               enable_in,
	input  logic                               start,
	input  logic [cu_pkg::COUNT_BITS-1:0]      num_vertices,
	input  logic [cu_pkg::COUNT_BITS-1:0]      num_edges,
	input  logic [cu_pkg::ADDR_BITS-1:0]       vertex_base,
	input  logic [cu_pkg::ADDR_BITS-1:0]       edge_base,
	input  logic                               read_cmd_alfull,
	output logic                               read_cmd_valid,
	output logic                               read_cmd_cu_id,
	output logic [cu_pkg::ADDR_BITS-1:0]       read_cmd_addr,
	input  logic                               read_data_valid,
	input  logic                               read_data_cu_id,
	input  cu_pkg::graph_word                  read_data,
	output logic                               status_valid,
	output logic [cu_pkg::COUNT_BITS-1:0]      status_edges,
	output logic [cu_pkg::COUNT_BITS-1:0]      status_vertices,
	output logic [cu_pkg::WEIGHT_SUM_BITS-1:0] status_weight_sum
);

	logic                                           enabled;
	logic                                           start_q;
	logic [cu_pkg::COUNT_BITS-1:0]                  num_vertices_q;
	logic [cu_pkg::COUNT_BITS-1:0]                  num_edges_q;
	logic [cu_pkg::ADDR_BITS-1:0]                   vertex_base_q;
	logic [cu_pkg::ADDR_BITS-1:0]                   edge_base_q;
	logic                                           data_valid_q;
	logic                                           data_cu_id_q;
	cu_pkg::graph_word                              data_q;
	logic                                           vertex_data_valid;
	logic                                           edge_data_valid;
	cu_pkg::graph_word                              routed_data;
	logic [NUM_REQUESTS-1:0]                        cmd_push;
	logic [NUM_REQUESTS-1:0][cu_pkg::ADDR_BITS-1:0] cmd_addr;
	logic [NUM_REQUESTS-1:0][cu_pkg::ADDR_BITS-1:0] cmd_head;
	logic [NUM_REQUESTS-1:0]                        fifo_alfull;
	logic [NUM_REQUESTS-1:0]                        fifo_empty;
	logic [NUM_REQUESTS-1:0]                        requests;
	logic [NUM_REQUESTS-1:0]                        ready;
	logic                                           arb_valid;
	logic [$clog2(NUM_REQUESTS)+cu_pkg::ADDR_BITS-1:0] arb_cmd;
	logic [1:0]                                     request_pulse;
	logic                                           job_request;
	logic                                           job_valid;
	logic [cu_pkg::COUNT_BITS-1:0]                  job_edge_start;
	logic [cu_pkg::DEGREE_BITS-1:0]                 job_degree;
	logic [cu_pkg::COUNT_BITS-1:0]                  filtered;
	logic [cu_pkg::COUNT_BITS-1:0]                  vertex_done;
	logic [cu_pkg::COUNT_BITS-1:0]                  edge_done;
	logic [cu_pkg::WEIGHT_SUM_BITS-1:0]             weight_sum;
	logic [cu_pkg::COUNT_BITS-1:0]                  filtered_q;
	logic [cu_pkg::COUNT_BITS-1:0]                  vertex_done_q;
	logic [cu_pkg::COUNT_BITS-1:0]                  edge_done_q;
	logic [cu_pkg::WEIGHT_SUM_BITS-1:0]             weight_sum_q;
	logic                                           running;
	logic                                           done;

	////////////////////
	// input latches and routing
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			enabled           <= 1'b0;
			start_q           <= 1'b0;
			num_vertices_q    <= '0;
			num_edges_q       <= '0;
			vertex_base_q     <= '0;
			edge_base_q       <= '0;
			data_valid_q      <= 1'b0;
			data_cu_id_q      <= 1'b0;
			vertex_data_valid <= 1'b0;
			edge_data_valid   <= 1'b0;
		end else begin
			enabled <= enable_in;
			// strobes never repeat while disabled
			start_q           <= enabled && start;
			data_valid_q      <= enabled && read_data_valid;
			vertex_data_valid <= enabled && data_valid_q
				&& data_cu_id_q == cu_pkg::VERTEX_CONTROL_ID;
			edge_data_valid   <= enabled && data_valid_q
				&& data_cu_id_q == cu_pkg::EDGE_CONTROL_ID;
			if (enabled) begin
				data_cu_id_q <= read_data_cu_id;
				if (start) begin
					num_vertices_q <= num_vertices;
					num_edges_q    <= num_edges;
					vertex_base_q  <= vertex_base;
					edge_base_q    <= edge_base;
				end
			end
		end
	end

	always_ff @(posedge clock) begin
		if (enabled) begin
			data_q      <= read_data;
			routed_data <= data_q;
		end
	end

	////////////////////
	// command path
	////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			request_pulse <= '0;
		end else begin
			request_pulse <= request_pulse + 1'b1;
		end
	end

	// grant slot on every fourth cycle and none under back-pressure
	assign requests = ~fifo_empty
		& {NUM_REQUESTS{!read_cmd_alfull && request_pulse == 2'd0}};

	for (genvar i = 0; i < NUM_REQUESTS; i++) begin : g_cmd_fifo
		cmd_fifo #(
			.WIDTH(cu_pkg::ADDR_BITS),
			.DEPTH(CMD_FIFO_DEPTH)
		) u_cmd_fifo (
			.clock   (clock),
			.rstn    (rstn),
			.push    (cmd_push[i]),
			.data_in (cmd_addr[i]),
			.pop     (ready[i]),
			.data_out(cmd_head[i]),
			.full    (),
			.alfull  (fifo_alfull[i]),
			.empty   (fifo_empty[i])
		);
	end

	cmd_arbiter #(
		.NUM_REQUESTS(NUM_REQUESTS)
	) u_cmd_arbiter (
		.clock        (clock),
		.rstn         (rstn),
		.enable_in    (enabled),
		.requests     (requests),
		.cmd_in       (cmd_head),
		.ready        (ready),
		.cmd_out_valid(arb_valid),
		.cmd_out      (arb_cmd)
	);

	////////////////////
	// job controllers
	////////////////////

	vertex_job_control #(
		.FIFO_DEPTH(CMD_FIFO_DEPTH)
	) u_vertex_job_control (
		.clock         (clock),
		.rstn          (rstn),
		.enable_in     (enabled),
		.start         (start_q),
		.num_vertices  (num_vertices_q),
		.vertex_base   (vertex_base_q),
		.data_valid    (vertex_data_valid),
		.data          (routed_data),
		.cmd_alfull    (fifo_alfull[cu_pkg::VERTEX_CONTROL_ID]),
		.cmd_push      (cmd_push[cu_pkg::VERTEX_CONTROL_ID]),
		.cmd_addr      (cmd_addr[cu_pkg::VERTEX_CONTROL_ID]),
		.job_request   (job_request),
		.job_valid     (job_valid),
		.job_edge_start(job_edge_start),
		.job_degree    (job_degree),
		.filtered_count(filtered)
	);

	edge_job_control u_edge_job_control (
		.clock            (clock),
		.rstn             (rstn),
		.enable_in        (enabled),
		.start            (start_q),
		.edge_base        (edge_base_q),
		.job_valid        (job_valid),
		.job_edge_start   (job_edge_start),
		.job_degree       (job_degree),
		.job_request      (job_request),
		.cmd_alfull       (fifo_alfull[cu_pkg::EDGE_CONTROL_ID]),
		.cmd_push         (cmd_push[cu_pkg::EDGE_CONTROL_ID]),
		.cmd_addr         (cmd_addr[cu_pkg::EDGE_CONTROL_ID]),
		.data_valid       (edge_data_valid),
		.data             (routed_data),
		.vertex_done_count(vertex_done),
		.edge_done_count  (edge_done),
		.weight_sum       (weight_sum)
	);

	////////////////////
	// outputs and completion
	////////////////////

	assign done = running && num_vertices_q == filtered_q + vertex_done_q
		&& num_edges_q == edge_done_q;

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			read_cmd_valid    <= 1'b0;
			read_cmd_cu_id    <= 1'b0;
			read_cmd_addr     <= '0;
			filtered_q        <= '0;
			vertex_done_q     <= '0;
			edge_done_q       <= '0;
			weight_sum_q      <= '0;
			running           <= 1'b0;
			status_valid      <= 1'b0;
			status_edges      <= '0;
			status_vertices   <= '0;
			status_weight_sum <= '0;
		end else if (enabled) begin
			read_cmd_valid                  <= arb_valid;
			{read_cmd_cu_id, read_cmd_addr} <= arb_cmd;
			if (start_q) begin
				// controllers clear on this edge too
				filtered_q        <= '0;
				vertex_done_q     <= '0;
				edge_done_q       <= '0;
				weight_sum_q      <= '0;
				running           <= 1'b1;
				status_valid      <= 1'b0;
				status_edges      <= '0;
				status_vertices   <= '0;
				status_weight_sum <= '0;
			end else begin
				filtered_q    <= filtered;
				vertex_done_q <= vertex_done;
				edge_done_q   <= edge_done;
				weight_sum_q  <= weight_sum;
				if (done) begin
					status_valid      <= 1'b1;
					status_edges      <= edge_done_q;
					status_vertices   <= filtered_q + vertex_done_q;
					status_weight_sum <= weight_sum_q;
				end
			end
		end
	end

	// vertex total that feeds status_vertices never passes the descriptor
	assert property (@(posedge clock) disable iff (!rstn)
		running && !start_q |-> filtered_q + vertex_done_q <= num_vertices_q)
		else $error("cu_control: status_vertices above num_vertices");

endmodule

/* dv/graph_mem_model.sv */
////////////////////
// memory model for the graph compute unit
// builds a random graph on build, answers reads in order
// after 1 to 4 cycles, raises almost-full in short bursts
////////////////////

module graph_mem_model (
	input  logic                               clock,
	input  logic                               build,
	input  logic [cu_pkg::COUNT_BITS-1:0]      graph_vertices,
	input  logic [cu_pkg::ADDR_BITS-1:0]       vertex_base,
	input  logic [cu_pkg::ADDR_BITS-1:0]       edge_base,
	output logic [cu_pkg::COUNT_BITS-1:0]      graph_edges,
	output logic [cu_pkg::WEIGHT_SUM_BITS-1:0] graph_weight_sum,
	input  logic                               read_cmd_valid,
	input  logic                               read_cmd_cu_id,
	input  logic [cu_pkg::ADDR_BITS-1:0]       read_cmd_addr,
	output logic                               read_cmd_alfull,
	output logic                               read_data_valid,
	output logic                               read_data_cu_id,
	output cu_pkg::graph_word                  read_data
);

	timeunit 1ns;
	timeprecision 1ps;

	cu_pkg::graph_word mem [256];
	int                seed;
	int unsigned       cycle;
	int unsigned       last_due;
	int unsigned       alfull_left;
	logic [7:0]        pend_addr [$];
	logic              pend_id [$];
	int unsigned       pend_due [$];

	task automatic make_graph();
		cu_pkg::graph_word word;
		int unsigned       edge_count;
		int unsigned       degree;
		int unsigned       weight_total;
		int                dest;
		edge_count   = 0;
		weight_total = 0;
		// background pattern, every word differs
		for (int a = 0; a < 256; a++) begin
			mem[a] = {8'(a) ^ 8'hc3, 8'(a), ~8'(a), 8'h5a};
		end
		for (int v = 0; v < int'(graph_vertices); v++) begin
			degree = $random(seed) & 3;
			word   = '0;
			word.vertex_view.first_edge = 16'(edge_count);
			word.vertex_view.degree     = 8'(degree);
			mem[8'(vertex_base + 16'(v))] = word;
			for (int e = 0; e < int'(degree); e++) begin
				dest = ($random(seed) & 32'h7fff_ffff) % int'(graph_vertices);
				word = '0;
				word.edge_view.dest_vertex = 16'(dest);
				word.edge_view.weight      = 8'($random(seed));
				mem[8'(edge_base + 16'(edge_count))] = word;
				weight_total = weight_total + int'(word.edge_view.weight);
				edge_count++;
			end
		end
		graph_edges      = 16'(edge_count);
		graph_weight_sum = 24'(weight_total);
	endtask

	task automatic serve_cycle();
		int unsigned due;
		cycle++;
		read_data_valid = 1'b0;
		if (pend_due.size() != 0 && pend_due[0] <= cycle) begin
			read_data_valid = 1'b1;
			read_data_cu_id = pend_id[0];
			read_data       = mem[pend_addr[0]];
			pend_addr.delete(0);
			pend_id.delete(0);
			pend_due.delete(0);
		end
		if (read_cmd_valid) begin
			due = cycle + 1 + ($random(seed) & 3);
			// answers stay in command order
			if (due < last_due) begin
				due = last_due;
			end
			last_due = due;
			pend_addr.push_back(read_cmd_addr[7:0]);
			pend_id.push_back(read_cmd_cu_id);
			pend_due.push_back(due);
		end
		if (alfull_left != 0) begin
			alfull_left--;
		end else if (($random(seed) & 15) == 0) begin
			alfull_left = 3 + ($random(seed) & 3);
		end
		read_cmd_alfull = alfull_left != 0;
	endtask

	// graph built on the rising edge, bus driven on the falling edge
	initial begin
		seed             = 65282;
		cycle            = 0;
		last_due         = 0;
		alfull_left      = 0;
		graph_edges      = '0;
		graph_weight_sum = '0;
		read_cmd_alfull  = 1'b0;
		read_data_valid  = 1'b0;
		read_data_cu_id  = 1'b0;
		read_data        = '0;
		forever begin
			@(posedge clock);
			if (build) begin
				make_graph();
			end
			@(negedge clock);
			serve_cycle();
		end
	end

endmodule

/* dv/cu_control_tb.sv */
////////////////////
// testbench for the graph compute unit
// clock and reset, two descriptors, checks on the
// read commands, the back-pressure and the status
////////////////////

module cu_control_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int GRAPH_VERTICES = 20;
	localparam int STATUS_TIMEOUT = 20000;

	logic                               clock;
	logic                               rstn;
	logic                               enable_in;
	logic                               start;
	logic [cu_pkg::COUNT_BITS-1:0]      num_vertices;
	logic [cu_pkg::COUNT_BITS-1:0]      num_edges;
	logic [cu_pkg::ADDR_BITS-1:0]       vertex_base;
	logic [cu_pkg::ADDR_BITS-1:0]       edge_base;
	logic                               read_cmd_alfull;
	logic                               read_cmd_valid;
	logic                               read_cmd_cu_id;
	logic [cu_pkg::ADDR_BITS-1:0]       read_cmd_addr;
	logic                               read_data_valid;
	logic                               read_data_cu_id;
	cu_pkg::graph_word                  read_data;
	logic                               status_valid;
	logic [cu_pkg::COUNT_BITS-1:0]      status_edges;
	logic [cu_pkg::COUNT_BITS-1:0]      status_vertices;
	logic [cu_pkg::WEIGHT_SUM_BITS-1:0] status_weight_sum;
	logic                               build;
	logic                               build_seen;
	logic                               started;
	logic [cu_pkg::COUNT_BITS-1:0]      graph_edges;
	logic [cu_pkg::WEIGHT_SUM_BITS-1:0] graph_weight_sum;
	int                                 alfull_run;
	int                                 vertex_reads;
	int                                 edge_reads;
	logic                               vertex_seen [256];
	logic                               edge_seen [256];

	cu_control #(
		.CMD_FIFO_DEPTH(8),
		.NUM_REQUESTS  (2)
	) u_cu_control (
		.clock            (clock),
		.rstn             (rstn),
		.enable_in        (enable_in),
		.start            (start),
		.num_vertices     (num_vertices),
		.num_edges        (num_edges),
		.vertex_base      (vertex_base),
		.edge_base        (edge_base),
		.read_cmd_alfull  (read_cmd_alfull),
		.read_cmd_valid   (read_cmd_valid),
		.read_cmd_cu_id   (read_cmd_cu_id),
		.read_cmd_addr    (read_cmd_addr),
		.read_data_valid  (read_data_valid),
		.read_data_cu_id  (read_data_cu_id),
		.read_data        (read_data),
		.status_valid     (status_valid),
		.status_edges     (status_edges),
		.status_vertices  (status_vertices),
		.status_weight_sum(status_weight_sum)
	);

	graph_mem_model u_graph_mem_model (
		.clock           (clock),
		.build           (build),
		.graph_vertices  (num_vertices),
		.vertex_base     (vertex_base),
		.edge_base       (edge_base),
		.graph_edges     (graph_edges),
		.graph_weight_sum(graph_weight_sum),
		.read_cmd_valid  (read_cmd_valid),
		.read_cmd_cu_id  (read_cmd_cu_id),
		.read_cmd_addr   (read_cmd_addr),
		.read_cmd_alfull (read_cmd_alfull),
		.read_data_valid (read_data_valid),
		.read_data_cu_id (read_data_cu_id),
		.read_data       (read_data)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	task automatic report_mismatch(input string test, input int expected, input int actual);
		$display("ERR %s expected %0d actual %0d", test, expected, actual);
		$display("TEST FAIL");
		$fatal(1, "value check failed");
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("TEST FAIL");
		$fatal(1, "testbench stopped");
	endtask

	task automatic wait_for_status(input logic level, input int limit, input string test);
		int cycles;
		cycles = 0;
		while (status_valid !== level && cycles < limit) begin
			@(negedge clock);
			cycles++;
		end
		if (status_valid !== level) begin
			abort_run({test, " timed out waiting for status_valid"});
		end
	endtask

	////////////////////
	// checkers
	////////////////////

	always @(posedge clock) begin
		if (!rstn) begin
			alfull_run <= 0;
			build_seen <= 1'b0;
		end else begin
			alfull_run <= read_cmd_alfull ? alfull_run + 1 : 0;
			build_seen <= build;
		end
	end

	always @(negedge clock) begin : check_commands
		int offset;
		if (rstn && !started) begin
			assert (!read_cmd_valid && !status_valid)
				else abort_run("read command or status seen before the first start");
		end
		if (alfull_run >= 3) begin
			assert (!read_cmd_valid)
				else abort_run("read command issued while almost-full was held high");
		end
		// new graph, fresh bookkeeping
		if (build_seen) begin
			for (int i = 0; i < 256; i++) begin
				vertex_seen[i] = 1'b0;
				edge_seen[i]   = 1'b0;
			end
			vertex_reads = 0;
			edge_reads   = 0;
		end
		if (read_cmd_valid && read_cmd_cu_id == cu_pkg::VERTEX_CONTROL_ID) begin
			offset = int'(read_cmd_addr) - int'(vertex_base);
			assert (offset >= 0 && offset < int'(num_vertices))
				else abort_run("vertex read outside the vertex table");
			assert (!vertex_seen[offset[7:0]])
				else abort_run("vertex address read more than once");
			vertex_seen[offset[7:0]] = 1'b1;
			vertex_reads++;
		end
		if (read_cmd_valid && read_cmd_cu_id == cu_pkg::EDGE_CONTROL_ID) begin
			offset = int'(read_cmd_addr) - int'(edge_base);
			assert (offset >= 0 && offset < int'(num_edges))
				else abort_run("edge read outside the edge table");
			assert (!edge_seen[offset[7:0]])
				else abort_run("edge address read more than once");
			edge_seen[offset[7:0]] = 1'b1;
			edge_reads++;
		end
	end

	////////////////////
	// stimulus
	////////////////////

	task automatic run_descriptor(input string test, input logic [15:0] vbase,
		input logic [15:0] ebase);
		num_vertices = 16'(GRAPH_VERTICES);
		vertex_base  = vbase;
		edge_base    = ebase;
		build        = 1'b1;
		@(negedge clock);
		build     = 1'b0;
		num_edges = graph_edges;
		@(negedge clock);
		start   = 1'b1;
		started = 1'b1;
		@(negedge clock);
		start = 1'b0;
		// a previous status drops two cycles after start
		wait_for_status(1'b0, 4, {test, " status clear"});
		wait_for_status(1'b1, STATUS_TIMEOUT, {test, " completion"});
		assert (status_vertices == num_vertices)
			else report_mismatch({test, " status_vertices"}, int'(num_vertices),
				int'(status_vertices));
		assert (status_edges == graph_edges)
			else report_mismatch({test, " status_edges"}, int'(graph_edges),
				int'(status_edges));
		assert (status_weight_sum == graph_weight_sum)
			else report_mismatch({test, " status_weight_sum"}, int'(graph_weight_sum),
				int'(status_weight_sum));
		assert (vertex_reads == GRAPH_VERTICES)
			else report_mismatch({test, " vertex reads"}, GRAPH_VERTICES, vertex_reads);
		assert (edge_reads == int'(graph_edges))
			else report_mismatch({test, " edge reads"}, int'(graph_edges), edge_reads);
	endtask

	initial begin
		rstn         = 1'b0;
		enable_in    = 1'b0;
		start        = 1'b0;
		build        = 1'b0;
		started      = 1'b0;
		num_vertices = '0;
		num_edges    = '0;
		vertex_base  = '0;
		edge_base    = '0;
		repeat (16) @(negedge clock);
		rstn      = 1'b1;
		enable_in = 1'b1;
		// idle window before the first descriptor
		repeat (12) @(negedge clock);
		run_descriptor("graph_a", 16'h0010, 16'h0040);
		run_descriptor("graph_b", 16'h0080, 16'h00c0);
		$display("TEST PASS");
		$finish;
	end

endmodule

/* sim.f */
src/cu_pkg.sv
src/cmd_fifo.sv
src/cmd_arbiter.sv
src/vertex_job_control.sv
src/edge_job_control.sv
src/cu_control.sv
dv/graph_mem_model.sv
dv/cu_control_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP      = cu_control_tb
FILELIST = sim.f
LOG      = run.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove the build directory and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
